// ==== source/fpu_op_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// operation word and decoded control for the fpu slice
// opcodes outside the enum list decode as a no-op
// the modifier field is only meaningful for OP_PERM
// ~~~~~~~~~~~~~~~~~~~~
package fpu_op_pkg;

  // issued opcode, 5 bits
  typedef enum logic [4:0] {
    OP_AND       = 5'h01,
    OP_OR        = 5'h02,
    OP_XOR       = 5'h03,
    OP_ANDN      = 5'h04,
    OP_PERM      = 5'h08,
    OP_CMP_ORD   = 5'h10,
    OP_CMP_UNORD = 5'h11
  } fpu_opcode_t;

  // modifier bit positions for permute
  localparam int MOD_COPY_A = 0;
  localparam int MOD_SWAP   = 1;
  localparam int MOD_DUP    = 2;

  // logic_sel encodings
  localparam logic [1:0] LSEL_AND  = 2'd0;
  localparam logic [1:0] LSEL_OR   = 2'd1;
  localparam logic [1:0] LSEL_XOR  = 2'd2;
  localparam logic [1:0] LSEL_ANDN = 2'd3;

  typedef struct packed {
    fpu_opcode_t opcode;
    logic [2:0]  modifier;
  } fpu_op_t;

  // one-stage control bundle for both paths
  typedef struct packed {
    logic       is_logic;
    logic [1:0] logic_sel;
    logic       is_perm;
    logic       copy_a;
    logic       swap;
    logic       dup;
    logic       is_cmp;
    logic       ordered;
  } fpu_ctrl_t;

endpackage

// ==== source/fpu_data_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// data-side types for the fpu slice
// a 64-bit word is one double or two singles, never both at once
// exception codes are ordered by priority, invalid first
// ~~~~~~~~~~~~~~~~~~~~
package fpu_data_pkg;

  localparam int WORD_W = 64;
  localparam int EXP_W  = 11;
  localparam int FRAC_W = 52;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fpu_double_t;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } fpu_singles_t;

  // compare reads dbl, permute reads sgl
  typedef union packed {
    logic [WORD_W-1:0] raw;
    fpu_double_t       dbl;
    fpu_singles_t      sgl;
  } fpu_word_u;

  typedef struct packed {
    logic unord;
    logic gt;
    logic eq;
    logic lt;
  } cmp_flags_t;

  typedef struct packed {
    logic invalid;
    logic denormal;
  } exc_bits_t;

  localparam int EXC_CODE_W = 2;
  localparam logic [EXC_CODE_W-1:0] EXC_NONE     = 2'd0;
  localparam logic [EXC_CODE_W-1:0] EXC_INVALID  = 2'd1;
  localparam logic [EXC_CODE_W-1:0] EXC_DENORMAL = 2'd2;

  // src 0 is the register file, src k is bus k-1
  typedef struct packed {
    logic       late;
    logic [3:0] src;
  } fwd_sel_t;

endpackage

// ==== source/operand_forward.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// operand bypass select, registered at the issue edge
// late picks the bus value sampled one edge earlier
// src beyond NUM_FWD falls back to the register file
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_forward
  import fpu_data_pkg::*;
#(
  parameter int NUM_FWD = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_word_u               reg_val,
  input  fwd_sel_t                sel,
  input  fpu_word_u [NUM_FWD-1:0] fwd_bus,
  output fpu_word_u               operand
);

  fpu_word_u [NUM_FWD-1:0] fwd_late;
  fpu_word_u               pick;

  // one-cycle-old copy of every bus
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_late <= '0;
    end else begin
      fwd_late <= fwd_bus;
    end
  end

  always_comb begin
    pick = reg_val;
    for (int k = 0; k < NUM_FWD; k++) begin
      if (sel.src == k + 1) begin
        pick = sel.late ? fwd_late[k] : fwd_bus[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else begin
      operand <= pick;
    end
  end

endmodule

// ==== source/fpu_op_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// opcode decode into path controls, one register stage
// ctrl is all zero in a cycle without issue
// unknown opcodes leave every path enable clear
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_op_decode
  import fpu_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      issue,
  input  fpu_op_t   op,
  output fpu_ctrl_t ctrl,
  output logic      ctrl_valid
);

  fpu_ctrl_t dec;

  always_comb begin
    dec = '0;
    case (op.opcode)
      OP_AND: begin
        dec.is_logic  = 1'b1;
        dec.logic_sel = LSEL_AND;
      end
      OP_OR: begin
        dec.is_logic  = 1'b1;
        dec.logic_sel = LSEL_OR;
      end
      OP_XOR: begin
        dec.is_logic  = 1'b1;
        dec.logic_sel = LSEL_XOR;
      end
      OP_ANDN: begin
        dec.is_logic  = 1'b1;
        dec.logic_sel = LSEL_ANDN;
      end
      OP_PERM: begin
        dec.is_perm = 1'b1;
        dec.copy_a  = op.modifier[MOD_COPY_A];
        dec.swap    = op.modifier[MOD_SWAP];
        dec.dup     = op.modifier[MOD_DUP];
      end
      OP_CMP_ORD: begin
        dec.is_cmp  = 1'b1;
        dec.ordered = 1'b1;
      end
      OP_CMP_UNORD: dec.is_cmp = 1'b1;
      default: dec = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl       <= '0;
      ctrl_valid <= 1'b0;
    end else begin
      ctrl       <= issue ? dec : '0;
      ctrl_valid <= issue;
    end
  end

endmodule

// ==== source/fpu_logic_perm.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// bitwise logic on 64-bit words and single-lane permute
// permute order is source pick, then swap, then dup
// result is zero for any other operation
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_logic_perm
  import fpu_op_pkg::*, fpu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fpu_ctrl_t ctrl,
  input  fpu_word_u a,
  input  fpu_word_u b,
  output fpu_word_u lp_res
);

  fpu_word_u nxt;

  always_comb begin
    nxt = '0;
    if (ctrl.is_logic) begin
      case (ctrl.logic_sel)
        LSEL_AND: nxt.raw = a.raw & b.raw;
        LSEL_OR:  nxt.raw = a.raw | b.raw;
        LSEL_XOR: nxt.raw = a.raw ^ b.raw;
        default:  nxt.raw = a.raw & ~b.raw;
      endcase
    end else if (ctrl.is_perm) begin
      nxt = ctrl.copy_a ? a : b;
      if (ctrl.swap) begin
        nxt.sgl = {nxt.sgl.lo, nxt.sgl.hi};
      end
      // dup works on the lanes after the swap
      if (ctrl.dup) begin
        nxt.sgl.hi = nxt.sgl.lo;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lp_res <= '0;
    end else begin
      lp_res <= nxt;
    end
  end

endmodule

// ==== source/fpu_compare.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// double compare, flags in the low 4 bits of the result
// a NaN gives unord only, +0 and -0 compare equal
// invalid only for ordered compares, denormal for either kind
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_compare
  import fpu_op_pkg::*, fpu_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fpu_ctrl_t ctrl,
  input  fpu_word_u a,
  input  fpu_word_u b,
  output fpu_word_u cmp_res,
  output exc_bits_t cmp_exc
);

  logic              a_nan, b_nan;
  logic              a_zero, b_zero;
  logic              a_den, b_den;
  logic [WORD_W-2:0] a_mag, b_mag;
  cmp_flags_t        flags;
  exc_bits_t         raised;

  always_comb begin
    a_nan  = (a.dbl.exp == '1) && (a.dbl.frac != '0);
    b_nan  = (b.dbl.exp == '1) && (b.dbl.frac != '0);
    a_zero = (a.dbl.exp == '0) && (a.dbl.frac == '0);
    b_zero = (b.dbl.exp == '0) && (b.dbl.frac == '0);
    a_den  = (a.dbl.exp == '0) && (a.dbl.frac != '0);
    b_den  = (b.dbl.exp == '0) && (b.dbl.frac != '0);
    a_mag  = a.raw[WORD_W-2:0];
    b_mag  = b.raw[WORD_W-2:0];

    flags = '0;
    if (a_nan || b_nan) begin
      flags.unord = 1'b1;
    end else if ((a_zero && b_zero) || (a.raw == b.raw)) begin
      flags.eq = 1'b1;
    end else if (a.dbl.sign != b.dbl.sign) begin
      flags.lt = a.dbl.sign;
      flags.gt = b.dbl.sign;
    end else if ((a_mag > b_mag) ^ a.dbl.sign) begin
      // sign-magnitude, larger magnitude is smaller when negative
      flags.gt = 1'b1;
    end else begin
      flags.lt = 1'b1;
    end

    raised.invalid  = ctrl.ordered && (a_nan || b_nan);
    raised.denormal = a_den || b_den;
  end

  always_ff @(posedge clk) begin
    if (rst || !ctrl.is_cmp) begin
      cmp_res <= '0;
      cmp_exc <= '0;
    end else begin
      cmp_res.raw <= {{(WORD_W - $bits(cmp_flags_t)){1'b0}}, flags};
      cmp_exc     <= raised;
    end
  end

endmodule

// ==== source/fpu_writeback.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// result merge and exception report
// ctrl is delayed one stage to line up with the path outputs
// invalid wins over denormal when both are enabled
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_writeback
  import fpu_op_pkg::*, fpu_data_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ctrl_valid,
  input  fpu_ctrl_t             ctrl,
  input  fpu_word_u             lp_res,
  input  fpu_word_u             cmp_res,
  input  exc_bits_t             cmp_exc,
  input  exc_bits_t             exc_enable,
  output logic                  res_valid,
  output fpu_word_u             res,
  output logic                  exc_valid,
  output logic [EXC_CODE_W-1:0] exc_code
);

  fpu_ctrl_t             ctrl_q;
  logic                  valid_q;
  exc_bits_t             masked;
  logic [EXC_CODE_W-1:0] code;

  always_comb begin
    masked.invalid  = cmp_exc.invalid & exc_enable.invalid;
    masked.denormal = cmp_exc.denormal & exc_enable.denormal;
    if (masked.invalid) code = EXC_INVALID;
    else if (masked.denormal) code = EXC_DENORMAL;
    else code = EXC_NONE;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q    <= '0;
      valid_q   <= 1'b0;
      res_valid <= 1'b0;
      res       <= '0;
      exc_valid <= 1'b0;
      exc_code  <= EXC_NONE;
    end else begin
      ctrl_q    <= ctrl;
      valid_q   <= ctrl_valid;
      res_valid <= valid_q;
      res       <= ctrl_q.is_cmp ? cmp_res : lp_res;
      exc_valid <= valid_q && (code != EXC_NONE);
      exc_code  <= valid_q ? code : EXC_NONE;
    end
  end

endmodule

// ==== source/fpu_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// fpu slice top: logic/permute and double compare
// fixed latency of 2 cycles from the issue edge, no back-pressure
// NUM_FWD result buses, 1 to 15
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_unit
  import fpu_op_pkg::*, fpu_data_pkg::*;
#(
  parameter int NUM_FWD = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue,
  input  fpu_op_t                       op,
  input  fpu_word_u                     reg_a,
  input  fpu_word_u                     reg_b,
  input  fwd_sel_t                      sel_a,
  input  fwd_sel_t                      sel_b,
  input  fpu_word_u [NUM_FWD-1:0]       fwd_bus,
  input  exc_bits_t                     exc_enable,
  output logic                          res_valid,
  output fpu_word_u                     res,
  output logic                          exc_valid,
  output logic [EXC_CODE_W-1:0]         exc_code
);

  fpu_word_u opnd_a;
  fpu_word_u opnd_b;
  fpu_ctrl_t ctrl;
  logic      ctrl_valid;
  fpu_word_u lp_res;
  fpu_word_u cmp_res;
  exc_bits_t cmp_exc;

  // stage 0: operands and control
  operand_forward #(.NUM_FWD(NUM_FWD)) u_fwd_a (
    .clk(clk), .rst(rst), .reg_val(reg_a), .sel(sel_a),
    .fwd_bus(fwd_bus), .operand(opnd_a)
  );

  operand_forward #(.NUM_FWD(NUM_FWD)) u_fwd_b (
    .clk(clk), .rst(rst), .reg_val(reg_b), .sel(sel_b),
    .fwd_bus(fwd_bus), .operand(opnd_b)
  );

  fpu_op_decode u_decode (
    .clk(clk), .rst(rst), .issue(issue), .op(op),
    .ctrl(ctrl), .ctrl_valid(ctrl_valid)
  );

  // stage 1: the two result paths
  fpu_logic_perm u_logic_perm (
    .clk(clk), .rst(rst), .ctrl(ctrl), .a(opnd_a), .b(opnd_b), .lp_res(lp_res)
  );

  fpu_compare u_compare (
    .clk(clk), .rst(rst), .ctrl(ctrl), .a(opnd_a), .b(opnd_b),
    .cmp_res(cmp_res), .cmp_exc(cmp_exc)
  );

  // stage 2: merge and exception report
  fpu_writeback u_writeback (
    .clk(clk), .rst(rst), .ctrl_valid(ctrl_valid), .ctrl(ctrl),
    .lp_res(lp_res), .cmp_res(cmp_res), .cmp_exc(cmp_exc), .exc_enable(exc_enable),
    .res_valid(res_valid), .res(res), .exc_valid(exc_valid), .exc_code(exc_code)
  );

endmodule

// ==== testbench/fpu_unit_vectors.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// vector table for the fpu slice testbench
// rows issue back to back in this order
// late forwarding rows read the bus of the row just before them
// ~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_UNIT_VECTORS_SVH
`define FPU_UNIT_VECTORS_SVH

localparam logic [63:0] LOG_A   = 64'hf0f0_f0f0_ff00_ff00;
localparam logic [63:0] LOG_B   = 64'h0ff0_0ff0_f0f0_f0f0;
localparam logic [63:0] PERM_A  = 64'ha1a1_a1a1_a0a0_a0a0;
localparam logic [63:0] PERM_B  = 64'hb1b1_b1b1_b0b0_b0b0;
localparam logic [63:0] D_ONE   = 64'h3ff0_0000_0000_0000;
localparam logic [63:0] D_TWO   = 64'h4000_0000_0000_0000;
localparam logic [63:0] D_MONE  = 64'hbff0_0000_0000_0000;
localparam logic [63:0] D_MTWO  = 64'hc000_0000_0000_0000;
localparam logic [63:0] D_MZERO = 64'h8000_0000_0000_0000;
localparam logic [63:0] D_NAN   = 64'h7ff8_0000_0000_0000;
localparam logic [63:0] D_DEN   = 64'h0000_0000_0000_0001;

// flag words {unord, gt, eq, lt} and enables {invalid, denormal}
localparam cmp_flags_t F_LT = 4'b0001;
localparam cmp_flags_t F_EQ = 4'b0010;
localparam cmp_flags_t F_GT = 4'b0100;
localparam cmp_flags_t F_UN = 4'b1000;
localparam exc_bits_t  EN_ALL = 2'b11;
localparam exc_bits_t  EN_INV = 2'b10;
localparam exc_bits_t  EN_DEN = 2'b01;

task automatic load_table();
  add_logic("and_fixed", OP_AND, LOG_A, LOG_B, 64'h00f0_00f0_f000_f000);
  add_logic("or_fixed", OP_OR, LOG_A, LOG_B, 64'hfff0_fff0_fff0_fff0);
  add_logic("xor_fixed", OP_XOR, LOG_A, LOG_B, 64'hff00_ff00_0ff0_0ff0);
  add_logic("andn_fixed", OP_ANDN, LOG_A, LOG_B, 64'hf000_f000_0f00_0f00);
  add_rand("and_rand", OP_AND);
  add_rand("or_rand", OP_OR);
  add_rand("xor_rand", OP_XOR);
  add_rand("andn_rand", OP_ANDN);
  // modifier is {dup, swap, copy_a}
  add_perm("perm_b", 3'b000, PERM_A, PERM_B, 64'hb1b1_b1b1_b0b0_b0b0);
  add_perm("perm_a", 3'b001, PERM_A, PERM_B, 64'ha1a1_a1a1_a0a0_a0a0);
  add_perm("perm_b_swap", 3'b010, PERM_A, PERM_B, 64'hb0b0_b0b0_b1b1_b1b1);
  add_perm("perm_a_swap", 3'b011, PERM_A, PERM_B, 64'ha0a0_a0a0_a1a1_a1a1);
  add_perm("perm_b_dup", 3'b100, PERM_A, PERM_B, 64'hb0b0_b0b0_b0b0_b0b0);
  add_perm("perm_a_dup", 3'b101, PERM_A, PERM_B, 64'ha0a0_a0a0_a0a0_a0a0);
  add_perm("perm_b_swap_dup", 3'b110, PERM_A, PERM_B, 64'hb1b1_b1b1_b1b1_b1b1);
  add_perm("perm_a_swap_dup", 3'b111, PERM_A, PERM_B, 64'ha1a1_a1a1_a1a1_a1a1);
  // sel is {late, src[3:0]}
  add_fwd("fwd_regfile", 5'h00, 5'h00, 64'h1234_5678_9abc_def0, '0,
          64'hc0c0_c0c0_c0c0_c000, 64'h1234_5678_9abc_def0);
  add_fwd("fwd_a_bus2_now", 5'h03, 5'h00, 64'hffff_0000_ffff_0000, '0,
          64'hd0d0_d0d0_d0d0_d000, 64'hd0d0_d0d0_d0d0_d002);
  add_fwd("fwd_a_bus1_late", 5'h12, 5'h00, 64'hffff_0000_ffff_0000, '0,
          64'he0e0_e0e0_e0e0_e000, 64'hd0d0_d0d0_d0d0_d001);
  add_fwd("fwd_b_bus0_late", 5'h00, 5'h11, '0, 64'h0000_ffff_0000_ffff,
          64'hf0f0_f0f0_f0f0_f000, 64'he0e0_e0e0_e0e0_e000);
  add_fwd("fwd_b_bus3_now", 5'h00, 5'h04, '0, 64'h0000_ffff_0000_ffff,
          64'h5a5a_5a5a_5a5a_5a00, 64'h5a5a_5a5a_5a5a_5a03);
  add_fwd("fwd_src_range", 5'h07, 5'h00, 64'h0123_4567_89ab_cdef, '0,
          64'h3c3c_3c3c_3c3c_3c00, 64'h0123_4567_89ab_cdef);
  add_cmp("cmp_ord_lt", OP_CMP_ORD, D_ONE, D_TWO, EN_ALL, F_LT, EXC_NONE);
  add_cmp("cmp_ord_eq", OP_CMP_ORD, D_TWO, D_TWO, EN_ALL, F_EQ, EXC_NONE);
  add_cmp("cmp_ord_gt", OP_CMP_ORD, D_TWO, D_ONE, EN_ALL, F_GT, EXC_NONE);
  add_cmp("cmp_unord_neg_lt", OP_CMP_UNORD, D_MTWO, D_MONE, EN_ALL, F_LT, EXC_NONE);
  add_cmp("cmp_unord_sign_gt", OP_CMP_UNORD, D_ONE, D_MTWO, EN_ALL, F_GT, EXC_NONE);
  add_cmp("cmp_zero_pm", OP_CMP_ORD, '0, D_MZERO, EN_ALL, F_EQ, EXC_NONE);
  add_cmp("cmp_ord_nan", OP_CMP_ORD, D_NAN, D_ONE, EN_ALL, F_UN, EXC_INVALID);
  add_cmp("cmp_ord_nan_masked", OP_CMP_ORD, D_NAN, D_ONE, EN_DEN, F_UN, EXC_NONE);
  add_cmp("cmp_unord_nan", OP_CMP_UNORD, D_ONE, D_NAN, EN_ALL, F_UN, EXC_NONE);
  add_cmp("cmp_denorm", OP_CMP_ORD, D_DEN, D_ONE, EN_ALL, F_LT, EXC_DENORMAL);
  add_cmp("cmp_denorm_masked", OP_CMP_ORD, D_DEN, D_ONE, EN_INV, F_LT, EXC_NONE);
  add_cmp("cmp_nan_denorm", OP_CMP_ORD, D_NAN, D_DEN, EN_ALL, F_UN, EXC_INVALID);
  // unknown opcode still returns a valid zero result
  add_logic("noop", fpu_opcode_t'(5'h1f), LOG_A, LOG_B, 64'h0);
endtask

`endif

// ==== testbench/fpu_unit_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the fpu slice, NUM_FWD fixed at 4
// one issue per cycle from the vector table, results checked 2 cycles later
// exc_enable is driven so that it lines up with each row's writeback edge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fpu_unit_tb
  import fpu_op_pkg::*, fpu_data_pkg::*;
();

  localparam int NUM_FWD   = 4;
  localparam int PERIOD    = 100;
  localparam int DRIVE_DLY = 1;

  typedef struct packed {
    fpu_op_t                 op;
    fpu_word_u               reg_a;
    fpu_word_u               reg_b;
    fwd_sel_t                sel_a;
    fwd_sel_t                sel_b;
    fpu_word_u [NUM_FWD-1:0] bus;
    exc_bits_t               exc_en;
    logic                    rnd;
    fpu_word_u               exp_res;
    logic [EXC_CODE_W-1:0]   exp_code;
  } vec_t;

  logic                    clk;
  logic                    rst;
  logic                    issue;
  fpu_op_t                 op;
  fpu_word_u               reg_a;
  fpu_word_u               reg_b;
  fwd_sel_t                sel_a;
  fwd_sel_t                sel_b;
  fpu_word_u [NUM_FWD-1:0] fwd_bus;
  exc_bits_t               exc_enable;
  logic                    res_valid;
  fpu_word_u               res;
  logic                    exc_valid;
  logic [EXC_CODE_W-1:0]   exc_code;

  vec_t   vecs[$];
  string  names[$];
  // row index per issue slot, -1 for an idle slot
  int     pending[$];
  integer seed = 32'hcb4f_eeb9;
  logic   loaded = 1'b0;

  fpu_unit #(.NUM_FWD(NUM_FWD)) u_dut (
    .clk(clk), .rst(rst), .issue(issue), .op(op),
    .reg_a(reg_a), .reg_b(reg_b), .sel_a(sel_a), .sel_b(sel_b),
    .fwd_bus(fwd_bus), .exc_enable(exc_enable),
    .res_valid(res_valid), .res(res), .exc_valid(exc_valid), .exc_code(exc_code)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic add_row(input string name, input fpu_op_t op_w, input logic [63:0] ra,
                         input logic [63:0] rb, input fwd_sel_t sa, input fwd_sel_t sb,
                         input logic [63:0] bus_base, input exc_bits_t en, input logic rnd,
                         input logic [63:0] exp_w, input logic [EXC_CODE_W-1:0] code);
    vec_t v;
    v.op        = op_w;
    v.reg_a.raw = ra;
    v.reg_b.raw = rb;
    v.sel_a     = sa;
    v.sel_b     = sb;
    // bus k carries base + k
    for (int k = 0; k < NUM_FWD; k++) begin
      v.bus[k].raw = bus_base + 64'(k);
    end
    v.exc_en      = en;
    v.rnd         = rnd;
    v.exp_res.raw = exp_w;
    v.exp_code    = code;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  task automatic add_logic(input string name, input fpu_opcode_t opc, input logic [63:0] a,
                           input logic [63:0] b, input logic [63:0] exp_w);
    add_row(name, {opc, 3'b000}, a, b, '0, '0, '0, 2'b11, 1'b0, exp_w, EXC_NONE);
  endtask

  task automatic add_rand(input string name, input fpu_opcode_t opc);
    add_row(name, {opc, 3'b000}, '0, '0, '0, '0, '0, 2'b11, 1'b1, '0, EXC_NONE);
  endtask

  task automatic add_perm(input string name, input logic [2:0] modifier, input logic [63:0] a,
                          input logic [63:0] b, input logic [63:0] exp_w);
    add_row(name, {OP_PERM, modifier}, a, b, '0, '0, '0, 2'b11, 1'b0, exp_w, EXC_NONE);
  endtask

  task automatic add_cmp(input string name, input fpu_opcode_t opc, input logic [63:0] a,
                         input logic [63:0] b, input exc_bits_t en, input cmp_flags_t flags,
                         input logic [EXC_CODE_W-1:0] code);
    add_row(name, {opc, 3'b000}, a, b, '0, '0, '0, en, 1'b0, {60'd0, flags}, code);
  endtask

  // forwarding rows use OR so an operand of zero passes the other through
  task automatic add_fwd(input string name, input fwd_sel_t sa, input fwd_sel_t sb,
                         input logic [63:0] ra, input logic [63:0] rb,
                         input logic [63:0] bus_base, input logic [63:0] exp_w);
    add_row(name, {OP_OR, 3'b000}, ra, rb, sa, sb, bus_base, 2'b11, 1'b0, exp_w, EXC_NONE);
  endtask

  `include "fpu_unit_vectors.svh"

  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    w[63:32] = $random(seed);
    w[31:0]  = $random(seed);
    return w;
  endfunction

  // reference for the four bitwise ops
  function automatic fpu_word_u logic_model(input fpu_opcode_t opc, input fpu_word_u a,
                                            input fpu_word_u b);
    fpu_word_u r;
    case (opc)
      OP_AND:  r.raw = a.raw & b.raw;
      OP_OR:   r.raw = a.raw | b.raw;
      OP_XOR:  r.raw = a.raw ^ b.raw;
      OP_ANDN: r.raw = a.raw & ~b.raw;
      default: r.raw = '0;
    endcase
    return r;
  endfunction

  task automatic check_word(input string name, input fpu_word_u exp_w, input fpu_word_u act_w);
    if (act_w !== exp_w) begin
      $display("[FAIL] %s res expected %h actual %h", name, exp_w.raw, act_w.raw);
      $display("TEST FAIL");
      $fatal(1, "result word mismatch");
    end
  endtask

  task automatic check_code(input string name, input logic [EXC_CODE_W-1:0] exp_c,
                            input logic [EXC_CODE_W-1:0] act_c);
    if (act_c !== exp_c) begin
      $display("[FAIL] %s exc_code expected %0d actual %0d", name, exp_c, act_c);
      $display("TEST FAIL");
      $fatal(1, "exception code mismatch");
    end
  endtask

  task automatic check_flag(input string name, input string label, input logic exp_f,
                            input logic act_f);
    if (act_f !== exp_f) begin
      $display("[FAIL] %s %s expected %b actual %b", name, label, exp_f, act_f);
      $display("TEST FAIL");
      $fatal(1, "status bit mismatch");
    end
  endtask

  task automatic drive_idle();
    issue   = 1'b0;
    op      = '0;
    reg_a   = '0;
    reg_b   = '0;
    sel_a   = '0;
    sel_b   = '0;
    fwd_bus = '0;
  endtask

  task automatic apply_vec(input int idx);
    vec_t v;
    if (idx < 0) begin
      drive_idle();
    end else begin
      v = vecs[idx];
      if (v.rnd) begin
        v.reg_a.raw = rand_word();
        v.reg_b.raw = rand_word();
        v.exp_res   = logic_model(v.op.opcode, v.reg_a, v.reg_b);
        vecs[idx]   = v;
      end
      issue   = 1'b1;
      op      = v.op;
      reg_a   = v.reg_a;
      reg_b   = v.reg_b;
      sel_a   = v.sel_a;
      sel_b   = v.sel_b;
      fwd_bus = v.bus;
    end
  endtask

  task automatic check_outputs(input int idx);
    vec_t v;
    if (idx < 0) begin
      check_flag("idle", "res_valid", 1'b0, res_valid);
      check_flag("idle", "exc_valid", 1'b0, exc_valid);
    end else begin
      v = vecs[idx];
      check_flag(names[idx], "res_valid", 1'b1, res_valid);
      check_word(names[idx], v.exp_res, res);
      check_code(names[idx], v.exp_code, exc_code);
      check_flag(names[idx], "exc_valid", v.exp_code != EXC_NONE, exc_valid);
    end
  endtask

  initial begin
    int idx;
    rst        = 1'b1;
    exc_enable = '0;
    drive_idle();
    load_table();
    loaded = 1'b1;
    // slots sampled during reset are idle
    repeat (3) pending.push_back(-1);
    repeat (2) @(posedge clk);
    #DRIVE_DLY rst = 1'b0;
    // two idle slots, the table back to back, then a flush
    for (int c = 0; c < vecs.size() + 5; c++) begin
      @(posedge clk);
      #DRIVE_DLY;
      check_outputs(pending.pop_front());
      idx = (c >= 2 && c < vecs.size() + 2) ? c - 2 : -1;
      // enable belongs to the row whose writeback edge comes next
      if (pending[0] >= 0) begin
        exc_enable = vecs[pending[0]].exc_en;
      end else begin
        exc_enable = '0;
      end
      apply_vec(idx);
      pending.push_back(idx);
    end
    $display("TEST PASS");
    $finish;
  end

  initial begin
    wait (loaded);
    #((vecs.size() + 10) * PERIOD);
    $display("watchdog: the run did not finish in time and was stopped");
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule

// ==== fpu_unit.f ====
+incdir+testbench
source/fpu_op_pkg.sv
source/fpu_data_pkg.sv
source/operand_forward.sv
source/fpu_op_decode.sv
source/fpu_logic_perm.sv
source/fpu_compare.sv
source/fpu_writeback.sv
source/fpu_unit.sv
testbench/fpu_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the fpu slice testbench with Verilator and runs it
# exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fpu_unit_tb \
  -f fpu_unit.f -o fpu_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/fpu_unit_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TEST PASS'; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
